// File: design/pwm_pkg.sv
`default_nettype none

package pwm_pkg;

    // Host register port widths
    typedef logic [7:0] reg_addr_t;
    typedef logic [15:0] reg_data_t;

    // Tick comes every 2**divider clock cycles
    typedef logic [2:0] divider_t;

    // One register access as the host presents it while req is high
    typedef struct packed {
        logic write;
        reg_addr_t addr;
        reg_data_t wdata;
    } reg_request_t;

    // Control word layout, fields listed from the most significant bit down
    // Bits 4 to 2 select the divider, bit 1 the external timebase, bit 0 run
    typedef struct packed {
        divider_t divider;
        logic ext_timebase_enable;
        logic run;
    } pwm_control_t;

    // Block zero holds the global registers
    localparam reg_addr_t CONTROL_ADDR = 8'h00;

    // Bit k of this register is the stopped value of pwm_out bit k
    localparam reg_addr_t STOPPED_STATE_ADDR = 8'h01;

    // Chain i starts at CHAIN_STRIDE * (i + 1)
    // Offset 0 is the period and offset 1 + c the compare value of channel c
    localparam reg_addr_t CHAIN_STRIDE = 8'h10;

endpackage

`default_nettype wire

// File: design/pwm_register_bank.sv
`default_nettype none

module pwm_register_bank
    import pwm_pkg::*;
#(
    parameter int N_CHAINS = 2,
    parameter int N_CHANNELS = 2,
    parameter int COUNTER_WIDTH = 8,
    localparam int N_PWM = 2 * N_CHAINS * N_CHANNELS
) (
    input logic clock,
    input logic reset,
    input logic req,
    input reg_request_t request,
    output logic ack,
    output reg_data_t rdata,
    output pwm_control_t control,
    output logic [N_PWM-1:0] stopped_state,
    output logic [N_CHAINS-1:0][COUNTER_WIDTH-1:0] period_values,
    output logic [N_CHAINS*N_CHANNELS-1:0][COUNTER_WIDTH-1:0] compare_values
);

    // Address split into a block number and an offset inside the block
    reg_addr_t block;
    reg_addr_t offset;
    // High in the single cycle where a new access is carried out
    logic access;
    reg_data_t read_value;

    assign block = request.addr / CHAIN_STRIDE;
    assign offset = request.addr % CHAIN_STRIDE;

    // A new access only starts once the previous acknowledge has dropped
    assign access = req && !ack;

    // Read mux over every mapped register, unmapped addresses read as zero
    always_comb begin
        read_value = '0;
        if (request.addr == CONTROL_ADDR) begin
            read_value = reg_data_t'(control);
        end else if (request.addr == STOPPED_STATE_ADDR) begin
            read_value = reg_data_t'(stopped_state);
        end
        for (int i = 0; i < N_CHAINS; i++) begin
            if (block == reg_addr_t'(i + 1)) begin
                if (offset == '0) begin
                    read_value = reg_data_t'(period_values[i]);
                end
                for (int c = 0; c < N_CHANNELS; c++) begin
                    if (offset == reg_addr_t'(c + 1)) begin
                        read_value = reg_data_t'(compare_values[i * N_CHANNELS + c]);
                    end
                end
            end
        end
    end

    // Register storage, values are truncated to the register width on write
    always_ff @(posedge clock) begin
        if (!reset) begin
            control <= '0;
            stopped_state <= '0;
            period_values <= '0;
            compare_values <= '0;
        end else if (access && request.write) begin
            if (request.addr == CONTROL_ADDR) begin
                control <= pwm_control_t'(request.wdata[$bits(pwm_control_t)-1:0]);
            end
            if (request.addr == STOPPED_STATE_ADDR) begin
                stopped_state <= N_PWM'(request.wdata);
            end
            for (int i = 0; i < N_CHAINS; i++) begin
                if (block == reg_addr_t'(i + 1)) begin
                    if (offset == '0) begin
                        period_values[i] <= COUNTER_WIDTH'(request.wdata);
                    end
                    for (int c = 0; c < N_CHANNELS; c++) begin
                        // Compare offsets start right after the period
                        if (offset == reg_addr_t'(c + 1)) begin
                            compare_values[i * N_CHANNELS + c] <= COUNTER_WIDTH'(request.wdata);
                        end
                    end
                end
            end
        end
    end

    // Four-phase slave, ack rises on the access edge and falls once req is low
    always_ff @(posedge clock) begin
        if (!reset) begin
            ack <= 1'b0;
        end else if (access) begin
            ack <= 1'b1;
        end else if (!req) begin
            ack <= 1'b0;
        end
    end

    // Read data is captured with the access and held while ack stays high
    always_ff @(posedge clock) begin
        if (access) begin
            rdata <= read_value;
        end
    end

endmodule

`default_nettype wire

// File: design/pwm_timebase.sv
`default_nettype none

module pwm_timebase
    import pwm_pkg::*;
(
    input logic clock,
    input logic reset,
    input pwm_control_t control,
    input logic ext_timebase,
    output logic tick,
    output logic timebase_out
);

    logic [6:0] prescaler;
    // Low bits of the prescaler that must all be set for an internal tick
    logic [6:0] mask;
    logic internal_hit;
    // Two synchronizer stages and the previous synchronized level
    logic [1:0] ext_sync;
    logic ext_previous;
    logic ext_edge;

    assign mask = 7'((8'd1 << control.divider) - 8'd1);
    assign internal_hit = (prescaler & mask) == mask;
    assign ext_edge = ext_sync[1] && !ext_previous;

    // With divider zero every cycle ticks, so the tick itself is exported
    assign timebase_out = (control.divider == '0) ? internal_hit
                                                  : prescaler[control.divider - 1'b1];

    always_ff @(posedge clock) begin
        if (!reset) begin
            prescaler <= '0;
            ext_sync <= '0;
            ext_previous <= 1'b0;
            tick <= 1'b0;
        end else begin
            prescaler <= prescaler + 7'd1;
            ext_sync <= {ext_sync[0], ext_timebase};
            ext_previous <= ext_sync[1];
            // Only one source drives the chains at a time
            tick <= control.ext_timebase_enable ? ext_edge : internal_hit;
        end
    end

endmodule

`default_nettype wire

// File: design/pwm_chain.sv
`default_nettype none

module pwm_chain #(
    parameter int N_CHANNELS = 2,
    parameter int COUNTER_WIDTH = 8
) (
    input logic clock,
    input logic reset,
    input logic run,
    input logic tick,
    input logic fault,
    input logic [COUNTER_WIDTH-1:0] period,
    input logic [N_CHANNELS-1:0][COUNTER_WIDTH-1:0] compare,
    input logic [2*N_CHANNELS-1:0] stopped_state,
    output logic [2*N_CHANNELS-1:0] pwm_out
);

    logic [COUNTER_WIDTH-1:0] counter;
    // Registered high side of every channel
    logic [N_CHANNELS-1:0] out_a;
    // Interleaved a/b pairs before the stop and fault override
    logic [2*N_CHANNELS-1:0] pair_out;

    // Counter stays at zero while stopped so a restart begins a fresh period
    always_ff @(posedge clock) begin
        if (!reset) begin
            counter <= '0;
        end else if (!run) begin
            counter <= '0;
        end else if (tick) begin
            // Wrap at the period, or at once if the period was lowered below the count
            if (counter >= period) begin
                counter <= '0;
            end else begin
                counter <= counter + 1'b1;
            end
        end
    end

    // High side is set while the count sits below the compare value
    always_ff @(posedge clock) begin
        if (!reset) begin
            out_a <= '0;
        end else begin
            for (int c = 0; c < N_CHANNELS; c++) begin
                out_a[c] <= counter < compare[c];
            end
        end
    end

    // Channel c puts out_a on bit 2c and its complement on bit 2c+1
    always_comb begin
        for (int c = 0; c < N_CHANNELS; c++) begin
            pair_out[2 * c] = out_a[c];
            pair_out[2 * c + 1] = !out_a[c];
        end
    end

    // The override acts in the same cycle, the outputs never wait for a clock edge
    assign pwm_out = (run && !fault) ? pair_out : stopped_state;

endmodule

`default_nettype wire

// File: design/pwm_generator.sv
`default_nettype none

module pwm_generator
    import pwm_pkg::*;
#(
    parameter int N_CHAINS = 2,
    parameter int N_CHANNELS = 2,
    parameter int COUNTER_WIDTH = 8,
    localparam int N_PWM = 2 * N_CHAINS * N_CHANNELS
) (
    input logic clock,
    input logic reset,
    input logic req,
    input reg_request_t request,
    output logic ack,
    output reg_data_t rdata,
    input logic ext_timebase,
    input logic fault,
    output logic timebase_out,
    output logic [N_PWM-1:0] pwm_out
);

    pwm_control_t control;
    logic [N_PWM-1:0] stopped_state;
    logic [N_CHAINS-1:0][COUNTER_WIDTH-1:0] period_values;
    logic [N_CHAINS*N_CHANNELS-1:0][COUNTER_WIDTH-1:0] compare_values;
    // Shared counting tick for every chain
    logic tick;

    pwm_register_bank #(
        .N_CHAINS(N_CHAINS),
        .N_CHANNELS(N_CHANNELS),
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) i_pwm_register_bank (
        .clock(clock),
        .reset(reset),
        .req(req),
        .request(request),
        .ack(ack),
        .rdata(rdata),
        .control(control),
        .stopped_state(stopped_state),
        .period_values(period_values),
        .compare_values(compare_values)
    );

    pwm_timebase i_pwm_timebase (
        .clock(clock),
        .reset(reset),
        .control(control),
        .ext_timebase(ext_timebase),
        .tick(tick),
        .timebase_out(timebase_out)
    );

    // Each chain takes its own slice of the register arrays and of pwm_out
    for (genvar i = 0; i < N_CHAINS; i++) begin : g_chain
        pwm_chain #(
            .N_CHANNELS(N_CHANNELS),
            .COUNTER_WIDTH(COUNTER_WIDTH)
        ) i_pwm_chain (
            .clock(clock),
            .reset(reset),
            .run(control.run),
            .tick(tick),
            .fault(fault),
            .period(period_values[i]),
            .compare(compare_values[i * N_CHANNELS +: N_CHANNELS]),
            .stopped_state(stopped_state[i * 2 * N_CHANNELS +: 2 * N_CHANNELS]),
            .pwm_out(pwm_out[i * 2 * N_CHANNELS +: 2 * N_CHANNELS])
        );
    end

endmodule

`default_nettype wire

// File: tests/pwm_generator_assertions.sv
`default_nettype none

module pwm_generator_assertions
    import pwm_pkg::*;
#(
    parameter int N_PWM = 8
) (
    input logic clock,
    input logic reset,
    input logic req,
    input logic ack,
    input logic fault,
    input pwm_control_t control,
    input logic [N_PWM-1:0] stopped_state,
    input logic [N_PWM-1:0] pwm_out
);
    timeunit 1ns;
    timeprecision 1ps;

    // Even bits are out_a, odd bits out_b
    logic [N_PWM/2-1:0] out_a_bits;
    logic [N_PWM/2-1:0] out_b_bits;

    always_comb begin
        for (int k = 0; k < N_PWM / 2; k++) begin
            out_a_bits[k] = pwm_out[2 * k];
            out_b_bits[k] = pwm_out[2 * k + 1];
        end
    end

    // The host already dropped req when ack is first seen, so look one edge back
    ack_rises_with_req: assert property (@(posedge clock) disable iff (!reset)
        $rose(ack) |-> $past(req)) else $error("ack rose while req was low");

    ack_falls_without_req: assert property (@(posedge clock) disable iff (!reset)
        $fell(ack) |-> !$past(req)) else $error("ack fell while req was high");

    fault_forces_stopped_state: assert property (@(posedge clock) disable iff (!reset)
        fault |-> pwm_out == stopped_state) else $error("pwm_out ignored the fault");

    running_pairs_complementary: assert property (@(posedge clock) disable iff (!reset)
        control.run && !fault |-> out_b_bits == ~out_a_bits)
        else $error("out_b is not the inverse of out_a");

endmodule

bind pwm_generator pwm_generator_assertions #(.N_PWM(N_PWM)) i_pwm_generator_assertions (
    .clock(clock),
    .reset(reset),
    .req(req),
    .ack(ack),
    .fault(fault),
    .control(control),
    .stopped_state(stopped_state),
    .pwm_out(pwm_out)
);

`default_nettype wire

// File: tests/pwm_generator_tb.sv
`default_nettype none

module pwm_generator_tb
    import pwm_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_CHAINS = 2;
    localparam int N_CHANNELS = 2;
    localparam int COUNTER_WIDTH = 8;
    localparam int N_PWM = 2 * N_CHAINS * N_CHANNELS;

    typedef logic [N_PWM-1:0] pwm_vector_t;

    logic clock;
    logic reset;
    logic req;
    reg_request_t request;
    logic ack;
    reg_data_t rdata;
    logic ext_timebase;
    logic fault;
    logic timebase_out;
    pwm_vector_t pwm_out;

    logic [31:0] lfsr_state;
    int cycle_count = 0;
    // Zero until the stim file has been scanned
    int timeout_limit = 0;
    // Only the background pulse process reads these
    int pulse_count;
    int pulse_spacing;
    // Divider and timebase source as last written to the control register
    int divider_exp = 0;
    logic ext_selected = 1'b0;
    string stim_lines[$];

    pwm_generator #(
        .N_CHAINS(N_CHAINS),
        .N_CHANNELS(N_CHANNELS),
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) i_pwm_generator (
        .clock(clock),
        .reset(reset),
        .req(req),
        .request(request),
        .ack(ack),
        .rdata(rdata),
        .ext_timebase(ext_timebase),
        .fault(fault),
        .timebase_out(timebase_out),
        .pwm_out(pwm_out)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_data(input string name, input reg_data_t actual,
                              input reg_data_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s is 0x%h, expected 0x%h",
                                $time, name, actual, expected));
        end
    endtask

    task automatic check_pwm(input string name, input pwm_vector_t actual,
                             input pwm_vector_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s is %b, expected %b",
                                $time, name, actual, expected));
        end
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        if (actual != expected) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s is %0d, expected %0d",
                                $time, name, actual, expected));
        end
    endtask

    // One four-phase access after an idle gap of 0 to 3 cycles
    task automatic bus_access(input logic write, input int addr, input int wdata,
                              output reg_data_t data);
        int gap;
        gap = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            gap = gap * 2 + int'(lfsr_state[0]);
        end
        repeat (gap) @(negedge clock);
        request.write = write;
        request.addr = reg_addr_t'(addr);
        request.wdata = reg_data_t'(wdata);
        req = 1'b1;
        @(negedge clock);
        while (!ack) @(negedge clock);
        data = rdata;
        req = 1'b0;
        @(negedge clock);
        while (ack) @(negedge clock);
    endtask

    // Half the spacing high, the rest low
    task automatic drive_pulses();
        for (int p = 0; p < pulse_count; p++) begin
            ext_timebase = 1'b1;
            repeat (pulse_spacing / 2) @(negedge clock);
            ext_timebase = 1'b0;
            repeat (pulse_spacing - pulse_spacing / 2) @(negedge clock);
        end
    endtask

    // Index N_PWM stands for timebase_out and lower indices for a pwm_out bit
    function automatic logic probe_level(input int index);
        if (index < N_PWM) return pwm_out[index];
        return timebase_out;
    endfunction

    // Times one full period starting at a rising edge, sampled on falling edges
    task automatic measure_output(input int bit_index, output int period_clocks,
                                  output int high_clocks);
        logic previous;
        period_clocks = 0;
        high_clocks = 0;
        previous = probe_level(bit_index);
        @(negedge clock);
        while (previous || !probe_level(bit_index)) begin
            previous = probe_level(bit_index);
            @(negedge clock);
        end
        // The first period may still straddle a change of the tick source
        while (probe_level(bit_index)) @(negedge clock);
        while (!probe_level(bit_index)) @(negedge clock);
        while (probe_level(bit_index)) begin
            high_clocks++;
            period_clocks++;
            @(negedge clock);
        end
        while (!probe_level(bit_index)) begin
            period_clocks++;
            @(negedge clock);
        end
    endtask

    // Worst case per command, measurements allow three expected periods
    function automatic int worst_case_cycles(input string line);
        string command;
        int first;
        int second;
        if ($sscanf(line, "%s %d %d", command, first, second) < 1) return 0;
        if (command == "write" || command == "read") return 8;
        if (command == "measure") return 3 * second;
        if (command == "pulses") return first * second;
        return 2;
    endfunction

    task automatic run_command(input string line);
        string command;
        int first;
        int second;
        int third;
        int period_clocks;
        int high_clocks;
        reg_data_t data;
        if ($sscanf(line, "%s", command) != 1) return;
        if (command.getc(0) == "#") return;
        if (command == "write" || command == "read") begin
            void'($sscanf(line, "%s %h %h", command, first, second));
            bus_access(command == "write", first, second, data);
            if (command == "read") begin
                check_data($sformatf("rdata at 0x%h", first), data, reg_data_t'(second));
            end else if (first == int'(CONTROL_ADDR)) begin
                // Divider sits in bits 4 to 2 and the timebase select in bit 1
                divider_exp = (second >> 2) & 7;
                ext_selected = second[1];
            end
        end else if (command == "outputs") begin
            void'($sscanf(line, "%s %h", command, first));
            check_pwm("pwm_out", pwm_out, pwm_vector_t'(first));
        end else if (command == "fault") begin
            void'($sscanf(line, "%s %d", command, first));
            fault = first[0];
            @(negedge clock);
        end else if (command == "pulses") begin
            void'($sscanf(line, "%s %d %d", command, pulse_count, pulse_spacing));
            fork
                drive_pulses();
            join_none
        end else if (command == "measure") begin
            void'($sscanf(line, "%s %d %d %d", command, first, second, third));
            measure_output(first, period_clocks, high_clocks);
            check_count($sformatf("period of pwm_out[%0d]", first), period_clocks, second);
            check_count($sformatf("high time of pwm_out[%0d]", first), high_clocks, third);
            // timebase_out is prescaler bit divider-1 and toggles every 2**(divider-1) clocks
            if (!ext_selected && divider_exp > 0) begin
                measure_output(N_PWM, period_clocks, high_clocks);
                check_count("period of timebase_out", period_clocks, 1 << divider_exp);
                check_count("high time of timebase_out", high_clocks, 1 << (divider_exp - 1));
            end
        end else begin
            abort_run($sformatf("Unknown command %s in the stim file", command));
        end
    endtask

    // Watchdog on the clock, armed once the limit is known
    initial begin
        while (timeout_limit == 0 || cycle_count <= timeout_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        abort_run($sformatf("Timeout: the test did not finish within %0d cycles", timeout_limit));
    end

    initial begin
        int fd;
        string line;
        req = 1'b0;
        request = '0;
        ext_timebase = 1'b0;
        fault = 1'b0;
        reset = 1'b0;
        lfsr_state = 32'h633f;
        fd = $fopen("tests/pwm_stim.txt", "r");
        if (fd == 0) abort_run("Could not open tests/pwm_stim.txt");
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0) stim_lines.push_back(line);
        end
        $fclose(fd);
        // Reset time and slack on top of the per-command worst cases
        timeout_limit = 200;
        foreach (stim_lines[i]) timeout_limit += worst_case_cycles(stim_lines[i]);
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        @(negedge clock);
        foreach (stim_lines[i]) run_command(stim_lines[i]);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/pwm_stim.txt
# write ADDR DATA, read ADDR EXPECTED, outputs EXPECTED: hex values
# fault LEVEL, pulses COUNT SPACING, measure BIT PERIOD HIGH: decimal, clocks
write 00 fffc
read 00 001c
write 01 ff5a
read 01 005a
write 10 1234
read 10 0034
write 11 abcd
read 11 00cd
write 20 0007
write 21 0003
write 22 0005
read 22 0005
read 05 0000
read 13 0000
write 30 00ff
write 05 0011
read 20 0007
read 01 005a
write 10 0009
write 11 0004
write 12 0007
outputs 5a
write 00 0001
measure 0 10 4
measure 1 10 6
measure 2 10 7
measure 4 8 3
measure 6 8 5
write 00 0009
measure 0 40 16
measure 6 32 20
fault 1
outputs 5a
fault 0
measure 4 32 12
write 00 0003
pulses 60 6
measure 0 60 24
measure 6 48 30
write 00 0000
outputs 5a

// File: sources.f
design/pwm_pkg.sv
design/pwm_register_bank.sv
design/pwm_timebase.sv
design/pwm_chain.sv
design/pwm_generator.sv
tests/pwm_generator_assertions.sv
tests/pwm_generator_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module pwm_generator_tb \
    -f sources.f -o pwm_sim
./obj_dir/pwm_sim
